/* build.f */
+incdir+src
src/ros2_msg_pkg.sv
src/ros2_ind_pkg.sv
src/topic_demux.sv
src/stream_to_reg.sv
src/pub_arbiter.sv
src/ros2_pub_top.sv
tests/ros2_pub_chk.sv
tests/pub_scoreboard.sv
tests/tb_ros2_pub.sv

/* Bender.yml */
package:
  name: ros2_pub

sources:
  - include_dirs:
      - src
    files:
      - src/ros2_msg_pkg.sv
      - src/ros2_ind_pkg.sv
      - src/topic_demux.sv
      - src/stream_to_reg.sv
      - src/pub_arbiter.sv
      - src/ros2_pub_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/ros2_pub_chk.sv
      - tests/pub_scoreboard.sv
      - tests/tb_ros2_pub.sv

/* tests/tb_ros2_pub.sv */
`include "ros2_config.svh"

module tb_ros2_pub
    import ros2_msg_pkg::*;
    import ros2_ind_pkg::*;
();

    localparam int NUM_MSGS   = 80;
    localparam int READY_WAIT = 200;  // Cycles per byte
    localparam int DRAIN_WAIT = 500;
    localparam int MAX_LEN    = `ROS2_MAX_APP_DATA_LEN;

    logic         clk_int = 1'b0;
    logic         rst_n_int;
    logic         pub_valid;
    msg_byte_t    pub_data;
    topic_id_t    pub_topic;
    logic         pub_last;
    logic         pub_ready;
    logic         msg_valid;
    topic_id_t    msg_topic;
    msg_payload_t msg_data;
    msg_len_t     msg_len;
    logic         led_r;
    logic         led_g;
    logic         led_b;
    logic [31:0]  rng;
    int           sb_errors;
    int           timeouts;
    int           stalls;

    always #2 clk_int = ~clk_int;

    ros2_pub_top i_dut (
        .clk_int     (clk_int),
        .rst_n_int   (rst_n_int),
        .i_pub_valid (pub_valid),
        .i_pub_data  (pub_data),
        .i_pub_topic (pub_topic),
        .i_pub_last  (pub_last),
        .o_pub_ready (pub_ready),
        .o_msg_valid (msg_valid),
        .o_msg_topic (msg_topic),
        .o_msg_data  (msg_data),
        .o_msg_len   (msg_len),
        .o_led_r     (led_r),
        .o_led_g     (led_g),
        .o_led_b     (led_b)
    );

    pub_scoreboard u_sb (
        .clk_int     (clk_int),
        .rst_n_int   (rst_n_int),
        .i_pub_ready (pub_ready),
        .i_msg_valid (msg_valid),
        .i_msg_topic (msg_topic),
        .i_msg_data  (msg_data),
        .i_msg_len   (msg_len),
        .i_led_r     (led_r),
        .i_led_g     (led_g),
        .i_led_b     (led_b),
        .o_err_cnt   (sb_errors)
    );

    bind ros2_pub_top ros2_pub_chk u_chk (
        .clk_int     (clk_int),
        .rst_n_int   (rst_n_int),
        .i_pub_valid (i_pub_valid),
        .i_pub_ready (o_pub_ready),
        .i_pub_topic (i_pub_topic),
        .i_pub_last  (i_pub_last),
        .i_in_msg    (u_demux.in_msg),
        .i_msg_valid (o_msg_valid),
        .i_msg_topic (o_msg_topic)
    );

    // ==============================
    // Stimulus helpers
    // ==============================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift32(rng);
        return int'(rng % n);
    endfunction

    task automatic idle(input int cycles);
        @(negedge clk_int);
        pub_valid = 1'b0;
        pub_last  = 1'b0;
        repeat (cycles - 1) @(negedge clk_int);
    endtask

    // Holds the byte until a rising edge sees ready
    task automatic send_byte(input topic_id_t topic, input msg_byte_t data, input logic last);
        int waited;
        @(negedge clk_int);
        pub_valid = 1'b1;
        pub_topic = topic;
        pub_data  = data;
        pub_last  = last;
        waited    = 0;
        @(posedge clk_int);
        while (!pub_ready && waited < READY_WAIT) begin
            stalls++;
            waited++;
            @(posedge clk_int);
        end
        if (!pub_ready) begin
            timeouts++;
            $display("Timeout: o_pub_ready stayed low %0d cycles on topic %0d", waited, topic);
        end
    endtask

    task automatic send_msg();
        topic_id_t    topic;
        int           len;
        msg_byte_t    b;
        msg_payload_t exp_data;
        topic    = topic_id_t'(rand_below(`ROS2_NUM_TOPICS));
        len      = 1 + rand_below(40);
        exp_data = '0;  // Short message leaves zeros above its end
        for (int i = 0; i < len && timeouts == 0; i++) begin
            b = msg_byte_t'(rand_below(256));
            if (i < MAX_LEN) begin
                exp_data[i] = b;
            end
            send_byte(topic, b, i == len - 1);
        end
        if (timeouts == 0) begin
            u_sb.expect_msg(topic, msg_len_t'((len > MAX_LEN) ? MAX_LEN : len), exp_data);
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int gap;
        int drain;
        int cover_errs;
        int assert_errs;
        rst_n_int = 1'b0;
        pub_valid = 1'b0;
        pub_data  = '0;
        pub_topic = '0;
        pub_last  = 1'b0;
        rng       = 32'd86743;
        timeouts  = 0;
        stalls    = 0;
        repeat (4) @(posedge clk_int);
        @(negedge clk_int);
        rst_n_int = 1'b1;

        for (int m = 0; m < NUM_MSGS && timeouts == 0; m++) begin
            // Second half back to back, so full channels stall the stream
            gap = (m < NUM_MSGS / 2) ? rand_below(6) : 0;
            if (gap > 0) begin
                idle(gap);
            end
            send_msg();
        end
        idle(1);

        drain = 0;
        while (u_sb.outstanding() != 0 && drain < DRAIN_WAIT) begin
            drain++;
            @(negedge clk_int);
        end
        if (u_sb.outstanding() != 0) begin
            timeouts++;
            $display("Timeout: %0d messages never published", u_sb.outstanding());
        end
        cover_errs = 0;
        if (stalls == 0) begin
            cover_errs = 1;
            $display("Back-pressure never occurred, o_pub_ready was never low");
        end
        assert_errs = i_dut.u_chk.fail_cnt;

        $display("Errors: %0d compare, %0d assertion, %0d timeout, %0d coverage (%0d stall cycles)",
                 sb_errors, assert_errs, timeouts, cover_errs, stalls);
        if (sb_errors == 0 && assert_errs == 0 && timeouts == 0 && cover_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tests/pub_scoreboard.sv */
`include "ros2_config.svh"

module pub_scoreboard
    import ros2_msg_pkg::*;
    import ros2_ind_pkg::*;
(
    input  logic         clk_int,
    input  logic         rst_n_int,
    input  logic         i_pub_ready,
    input  logic         i_msg_valid,
    input  topic_id_t    i_msg_topic,
    input  msg_payload_t i_msg_data,
    input  msg_len_t     i_msg_len,
    input  logic         i_led_r,
    input  logic         i_led_g,
    input  logic         i_led_b,
    output int           o_err_cnt
);

    typedef struct packed {
        topic_id_t    topic;
        msg_len_t     len;
        msg_payload_t data;
    } exp_msg_t;

    exp_msg_t    exp_q[$];  // First entry of a topic is that topic's front
    size_class_e exp_cls = NONE;
    int          err_cnt = 0;

    assign o_err_cnt = err_cnt;

    function automatic size_class_e class_of(input int len);
        if (len == 0) begin
            return NONE;
        end else if (len <= `ROS2_LED_R_MAX) begin
            return SMALL;
        end else if (len <= `ROS2_LED_G_MAX) begin
            return MEDIUM;
        end
        return LARGE;
    endfunction

    task automatic expect_msg(input topic_id_t topic, input msg_len_t len,
                              input msg_payload_t data);
        exp_msg_t m;
        m.topic = topic;
        m.len   = len;
        m.data  = data;
        exp_q.push_back(m);
    endtask

    function automatic int outstanding();
        return exp_q.size();
    endfunction

    // ==============================
    // Compare at the falling edge
    // ==============================

    always @(negedge clk_int) begin
        exp_msg_t   m;
        int         idx;
        int         bad;
        logic [2:0] exp_led;
        if (!rst_n_int) begin
            exp_cls = NONE;
            if (i_msg_valid || !i_pub_ready) begin
                err_cnt++;
                $display("FAIL @%0t: reset state valid %b ready %b", $time, i_msg_valid,
                         i_pub_ready);
            end
        end else if (i_msg_valid) begin
            idx = -1;
            for (int i = 0; i < exp_q.size(); i++) begin
                if (idx < 0 && exp_q[i].topic == i_msg_topic) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                err_cnt++;
                exp_cls = class_of(int'(i_msg_len));  // Keeps LED errors from piling up
                $display("FAIL @%0t: publication on topic %0d with nothing outstanding",
                         $time, i_msg_topic);
            end else begin
                m   = exp_q[idx];
                bad = -1;
                for (int b = 0; b < `ROS2_MAX_APP_DATA_LEN; b++) begin
                    if (bad < 0 && i_msg_data[b] !== m.data[b]) begin
                        bad = b;
                    end
                end
                if (i_msg_len !== m.len) begin
                    err_cnt++;
                    $display("FAIL @%0t: topic %0d length %0d, expected %0d", $time,
                             i_msg_topic, i_msg_len, m.len);
                end
                if (bad >= 0) begin
                    err_cnt++;
                    $display("FAIL @%0t: topic %0d byte %0d is %02h, expected %02h", $time,
                             i_msg_topic, bad, i_msg_data[bad], m.data[bad]);
                end
                exp_cls = class_of(int'(m.len));
                exp_q.delete(idx);
            end
        end
        case (exp_cls)
            SMALL:   exp_led = 3'b100;
            MEDIUM:  exp_led = 3'b010;
            LARGE:   exp_led = 3'b001;
            default: exp_led = 3'b000;
        endcase
        if ({i_led_r, i_led_g, i_led_b} !== exp_led) begin
            err_cnt++;
            $display("FAIL @%0t: LEDs rgb %b%b%b, expected %b", $time, i_led_r, i_led_g,
                     i_led_b, exp_led);
        end
    end

endmodule

/* tests/ros2_pub_chk.sv */
`include "ros2_config.svh"

module ros2_pub_chk
    import ros2_msg_pkg::*;
    import ros2_ind_pkg::*;
(
    input logic                        clk_int,
    input logic                        rst_n_int,
    input logic                        i_pub_valid,
    input logic                        i_pub_ready,
    input topic_id_t                   i_pub_topic,
    input logic                        i_pub_last,
    input logic [`ROS2_NUM_TOPICS-1:0] i_in_msg,
    input logic                        i_msg_valid,
    input topic_id_t                   i_msg_topic
);

    logic accept;
    int   fail_cnt = 0;  // Failed assertions so far

    assign accept = i_pub_valid && i_pub_ready;

    // ==============================
    // Port protocol
    // ==============================

    a_single_pulse: assert property (@(posedge clk_int) disable iff (!rst_n_int)
        (i_msg_valid && $past(i_msg_valid)) |-> (i_msg_topic != $past(i_msg_topic)))
        else begin
            fail_cnt++;
            $error("o_msg_valid held for two cycles on topic %0d", i_msg_topic);
        end

    // Channel is still filling one cycle after its last byte
    a_min_latency: assert property (@(posedge clk_int) disable iff (!rst_n_int)
        (accept && i_pub_last) |=> !(i_msg_valid && (i_msg_topic == $past(i_pub_topic))))
        else begin
            fail_cnt++;
            $error("o_msg_valid on topic %0d too soon after its last byte", i_msg_topic);
        end

    a_no_interleave: assert property (@(posedge clk_int) disable iff (!rst_n_int)
        (accept && (|i_in_msg)) |-> i_in_msg[i_pub_topic])
        else begin
            fail_cnt++;
            $error("topic %0d started while another message was open", i_pub_topic);
        end

endmodule

/* src/ros2_pub_top.sv */
`include "ros2_config.svh"

module ros2_pub_top (
    input  logic                                 clk_int,
    input  logic                                 rst_n_int,

    // Application byte stream
    input  logic                                 i_pub_valid,
    input  logic [7:0]                           i_pub_data,
    input  logic [$clog2(`ROS2_NUM_TOPICS)-1:0]  i_pub_topic,
    input  logic                                 i_pub_last,
    output logic                                 o_pub_ready,

    // Message toward the protocol core
    output logic                                 o_msg_valid,
    output logic [$clog2(`ROS2_NUM_TOPICS)-1:0]  o_msg_topic,
    output logic [`ROS2_MAX_APP_DATA_LEN*8-1:0]  o_msg_data,
    output logic [7:0]                           o_msg_len,

    output logic                                 o_led_r,
    output logic                                 o_led_g,
    output logic                                 o_led_b
);

    logic [`ROS2_NUM_TOPICS-1:0]                                ch_strobe;
    logic [7:0]                                                 ch_byte;
    logic                                                       ch_last;
    logic [`ROS2_NUM_TOPICS-1:0]                                ch_full;
    logic [`ROS2_NUM_TOPICS-1:0]                                ch_take;
    logic [`ROS2_NUM_TOPICS-1:0][`ROS2_MAX_APP_DATA_LEN*8-1:0]  ch_payload;
    logic [`ROS2_NUM_TOPICS-1:0][7:0]                           ch_len;

    topic_demux u_demux (
        .clk_int     (clk_int),
        .rst_n_int   (rst_n_int),
        .i_pub_valid (i_pub_valid),
        .i_pub_data  (i_pub_data),
        .i_pub_topic (i_pub_topic),
        .i_pub_last  (i_pub_last),
        .o_pub_ready (o_pub_ready),
        .o_ch_strobe (ch_strobe),
        .o_ch_data   (ch_byte),
        .o_ch_last   (ch_last),
        .i_ch_full   (ch_full)
    );

    // One assembly register per topic
    for (genvar g = 0; g < `ROS2_NUM_TOPICS; g++) begin : g_ch
        stream_to_reg u_s2r (
            .clk_int    (clk_int),
            .rst_n_int  (rst_n_int),
            .i_strobe   (ch_strobe[g]),
            .i_data     (ch_byte),
            .i_last     (ch_last),
            .i_take     (ch_take[g]),
            .o_full     (ch_full[g]),
            .o_data     (ch_payload[g]),
            .o_data_len (ch_len[g])
        );
    end

    pub_arbiter u_arb (
        .clk_int     (clk_int),
        .rst_n_int   (rst_n_int),
        .i_ch_full   (ch_full),
        .i_ch_data   (ch_payload),
        .i_ch_len    (ch_len),
        .o_ch_take   (ch_take),
        .o_msg_valid (o_msg_valid),
        .o_msg_topic (o_msg_topic),
        .o_msg_data  (o_msg_data),
        .o_msg_len   (o_msg_len),
        .o_led_r     (o_led_r),
        .o_led_g     (o_led_g),
        .o_led_b     (o_led_b)
    );

endmodule

/* src/pub_arbiter.sv */
`include "ros2_config.svh"

module pub_arbiter
    import ros2_msg_pkg::*;
    import ros2_ind_pkg::*;
(
    input  logic                                      clk_int,
    input  logic                                      rst_n_int,

    // Channel side
    input  logic [`ROS2_NUM_TOPICS-1:0]               i_ch_full,
    input  msg_payload_t [`ROS2_NUM_TOPICS-1:0]       i_ch_data,
    input  msg_len_t [`ROS2_NUM_TOPICS-1:0]           i_ch_len,
    output logic [`ROS2_NUM_TOPICS-1:0]               o_ch_take,

    // Published message
    output logic                                      o_msg_valid,
    output topic_id_t                                 o_msg_topic,
    output msg_payload_t                              o_msg_data,
    output msg_len_t                                  o_msg_len,

    // Size-class indicators
    output logic                                      o_led_r,
    output logic                                      o_led_g,
    output logic                                      o_led_b
);

    topic_id_t   last_q;  // Last granted channel
    topic_id_t   gnt_idx;
    logic        gnt_valid;
    logic        msg_valid_q;
    size_class_e size_q;
    led_rgb_t    led;

    function automatic size_class_e len_class(msg_len_t len);
        if (len == '0) begin
            return NONE;
        end else if (len <= msg_len_t'(`ROS2_LED_R_MAX)) begin
            return SMALL;
        end else if (len <= msg_len_t'(`ROS2_LED_G_MAX)) begin
            return MEDIUM;
        end
        return LARGE;
    endfunction

    // ==============================
    // Round-robin grant
    // ==============================

    // Search starts one past the last grant, the last grant itself comes last
    always_comb begin
        int unsigned cand;
        gnt_valid = 1'b0;
        gnt_idx   = last_q;
        for (int k = 1; k <= `ROS2_NUM_TOPICS; k++) begin
            cand = (int'(last_q) + k) % `ROS2_NUM_TOPICS;
            if (!gnt_valid && i_ch_full[cand]) begin
                gnt_valid = 1'b1;
                gnt_idx   = topic_id_t'(cand);
            end
        end
    end

    always_comb begin
        o_ch_take = '0;
        if (gnt_valid) begin
            o_ch_take[gnt_idx] = 1'b1;  // Frees the channel on the output edge
        end
    end

    // ==============================
    // Output registers
    // ==============================

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            last_q      <= topic_id_t'(`ROS2_NUM_TOPICS - 1);  // Topic 0 goes first
            msg_valid_q <= 1'b0;
            size_q      <= NONE;
        end else begin
            msg_valid_q <= gnt_valid;
            if (gnt_valid) begin
                last_q <= gnt_idx;
                size_q <= len_class(i_ch_len[gnt_idx]);
            end
        end
    end

    always_ff @(posedge clk_int) begin
        if (gnt_valid) begin
            o_msg_topic <= gnt_idx;
            o_msg_data  <= i_ch_data[gnt_idx];
            o_msg_len   <= i_ch_len[gnt_idx];
        end
    end

    assign o_msg_valid = msg_valid_q;

    // LEDs hold the class of the last publication
    assign led     = size_class_led(size_q);
    assign o_led_r = led.r;
    assign o_led_g = led.g;
    assign o_led_b = led.b;

endmodule

/* src/stream_to_reg.sv */
module stream_to_reg
    import ros2_msg_pkg::*;
(
    input  logic         clk_int,
    input  logic         rst_n_int,

    // Byte side from the demux
    input  logic         i_strobe,
    input  msg_byte_t    i_data,
    input  logic         i_last,

    // Message side to the arbiter
    input  logic         i_take,
    output logic         o_full,
    output msg_payload_t o_data,
    output msg_len_t     o_data_len
);

    logic                  full_q;
    logic                  busy_q;  // Inside a message
    msg_len_t              len_q;
    msg_payload_t          data_q;
    logic                  room;
    logic [BYTE_IDX_W-1:0] wr_pos;

    // Length doubles as the write position
    assign room   = (len_q < MSG_LEN_MAX);
    assign wr_pos = len_q[BYTE_IDX_W-1:0];

    // ==============================
    // Control
    // ==============================

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            full_q <= 1'b0;
            busy_q <= 1'b0;
            len_q  <= '0;
        end else begin
            if (i_strobe) begin
                busy_q <= ~i_last;
                if (!busy_q) begin
                    len_q <= msg_len_t'(1);  // First byte restarts the count
                end else if (room) begin
                    len_q <= len_q + msg_len_t'(1);
                end
            end

            if (i_strobe && i_last) begin
                full_q <= 1'b1;
            end else if (i_take) begin
                full_q <= 1'b0;
            end
        end
    end

    // ==============================
    // Payload
    // ==============================

    always_ff @(posedge clk_int) begin
        if (i_strobe) begin
            if (!busy_q) begin
                data_q    <= '0;  // Zero fill behind a short message
                data_q[0] <= i_data;
            end else if (room) begin
                data_q[wr_pos] <= i_data;
            end
            // Beyond the maximum the byte is taken and dropped
        end
    end

    assign o_full     = full_q;
    assign o_data     = data_q;
    assign o_data_len = len_q;

endmodule

/* src/topic_demux.sv */
`include "ros2_config.svh"

module topic_demux
    import ros2_msg_pkg::*;
(
    input  logic                        clk_int,
    input  logic                        rst_n_int,

    // Tagged byte stream from the control application
    input  logic                        i_pub_valid,
    input  msg_byte_t                   i_pub_data,
    input  topic_id_t                   i_pub_topic,
    input  logic                        i_pub_last,
    output logic                        o_pub_ready,

    // Per-channel side
    output logic [`ROS2_NUM_TOPICS-1:0] o_ch_strobe,
    output msg_byte_t                   o_ch_data,
    output logic                        o_ch_last,
    input  logic [`ROS2_NUM_TOPICS-1:0] i_ch_full
);

    logic                        accept;
    logic [`ROS2_NUM_TOPICS-1:0] sel_onehot;
    logic [`ROS2_NUM_TOPICS-1:0] in_msg;  // Topic has an open message

    // ==============================
    // Routing
    // ==============================

    assign o_pub_ready = ~i_ch_full[i_pub_topic];  // Full channel stalls the stream
    assign accept      = i_pub_valid & o_pub_ready;

    always_comb begin
        sel_onehot = '0;
        sel_onehot[i_pub_topic] = 1'b1;
    end

    assign o_ch_strobe = accept ? sel_onehot : '0;

    // Data and last are shared, only the strobe selects
    assign o_ch_data = i_pub_data;
    assign o_ch_last = i_pub_last;

    // ==============================
    // Open-message tracking
    // ==============================

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            in_msg <= '0;
        end else if (accept) begin
            in_msg[i_pub_topic] <= ~i_pub_last;  // Closed by the last byte
        end
    end

endmodule

/* src/ros2_ind_pkg.sv */
package ros2_ind_pkg;

    // ==============================
    // Size classes and LED encoding
    // ==============================

    typedef enum logic [1:0] {
        NONE   = 2'd0,  // Empty message
        SMALL  = 2'd1,  // Red
        MEDIUM = 2'd2,  // Green
        LARGE  = 2'd3   // Blue
    } size_class_e;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } led_rgb_t;

    // One LED per class, all dark for NONE
    function automatic led_rgb_t size_class_led(size_class_e cls);
        led_rgb_t led;
        led = '0;
        case (cls)
            SMALL:   led.r = 1'b1;
            MEDIUM:  led.g = 1'b1;
            LARGE:   led.b = 1'b1;
            default: led = '0;
        endcase
        return led;
    endfunction

endpackage

/* src/ros2_msg_pkg.sv */
`include "ros2_config.svh"

package ros2_msg_pkg;

    // ==============================
    // Derived widths
    // ==============================

    localparam int TOPIC_W    = $clog2(`ROS2_NUM_TOPICS);
    localparam int BYTE_IDX_W = $clog2(`ROS2_MAX_APP_DATA_LEN);  // Byte position in payload

    // ==============================
    // Message types
    // ==============================

    typedef logic [7:0] msg_byte_t;
    typedef logic [7:0] msg_len_t;  // Byte count
    typedef logic [TOPIC_W-1:0] topic_id_t;

    // Byte 0 sits in the lowest bits, same as the core's app data bus
    typedef msg_byte_t [`ROS2_MAX_APP_DATA_LEN-1:0] msg_payload_t;

    localparam msg_len_t MSG_LEN_MAX = msg_len_t'(`ROS2_MAX_APP_DATA_LEN);

endpackage

/* src/ros2_config.svh */
`ifndef ROS2_CONFIG_SVH
`define ROS2_CONFIG_SVH

// ==============================
// Publish path sizing
// ==============================

`define ROS2_MAX_APP_DATA_LEN 32  // Bytes per message
`define ROS2_NUM_TOPICS 4  // Channels behind the demux

// ==============================
// Size-class LED bounds
// ==============================

`define ROS2_LED_R_MAX 10  // Red up to this length
`define ROS2_LED_G_MAX 20  // Green up to this length, blue above

`endif
